//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN          = 32;
    localparam int REG_ADDR_BITS = 5;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // {instr[30], funct3} of the matching op
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

`default_nettype wire

//--- rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    typedef struct packed {
        logic                          valid;
        rv_isa_pkg::instr_u            instr;
        logic [rv_isa_pkg::XLEN-1:0]   pc;
    } fetch_t;

    typedef struct packed {
        logic                                 valid;
        logic [rv_isa_pkg::XLEN-1:0]          pc;
        logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs1;
        logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs2;
        logic [rv_isa_pkg::XLEN-1:0]          rs1_data;
        logic [rv_isa_pkg::XLEN-1:0]          rs2_data;
        logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rd;
        logic                                 wr_en;
        rv_isa_pkg::alu_op_e                  alu_op;
        logic [rv_isa_pkg::XLEN-1:0]          imm;
        logic                                 op1_pc;    // op1 = pc
        logic                                 op2_imm;   // op2 = imm
        logic                                 is_jal;
        logic                                 is_jalr;
        logic                                 is_branch;
        logic [2:0]                           funct3;    // branch condition
    } dec_t;

    typedef struct packed {
        logic                                 valid;
        logic                                 wr_en;
        logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rd;
        logic [rv_isa_pkg::XLEN-1:0]          data;
        logic [rv_isa_pkg::XLEN-1:0]          pc;
    } retire_t;

    typedef struct packed {
        logic                        taken;
        logic [rv_isa_pkg::XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

//--- rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000,
    parameter int          IADDR_BITS = 16
)
(
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_instr_ack,
    input  rv_isa_pkg::instr_u     i_instr_data,
    input  rv_pipe_pkg::redirect_t i_redirect,
    output logic                   o_instr_req,
    output logic [IADDR_BITS-1:0]  o_instr_addr,
    output rv_pipe_pkg::fetch_t    o_fetch
);

    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic                        req;
    logic                        accept;

    // late ack of a flushed request is dropped
    assign accept       = req & i_instr_ack & ~i_redirect.taken;
    assign o_instr_req  = req;
    assign o_instr_addr = pc[IADDR_BITS-1:0];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            pc      <= RESET_ADDR;
            req     <= 1'b0;
            o_fetch <= '0;
        end
        else
        begin
            req           <= 1'b1;    // one open request, always
            o_fetch.valid <= accept;
            if (accept)
            begin
                o_fetch.instr <= i_instr_data;
                o_fetch.pc    <= pc;
            end
            if (i_redirect.taken)
            begin
                pc <= i_redirect.target;
            end
            else if (accept)
            begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input  logic                                 i_clk,
    input  logic                                 i_arst_n,
    input  rv_pipe_pkg::fetch_t                  i_fetch,
    input  rv_pipe_pkg::redirect_t               i_redirect,
    input  logic [rv_isa_pkg::XLEN-1:0]          i_rs1_data,
    input  logic [rv_isa_pkg::XLEN-1:0]          i_rs2_data,
    output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] o_rs1,
    output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] o_rs2,
    output rv_pipe_pkg::dec_t                    o_dec
);

    rv_isa_pkg::instr_u instr;
    rv_pipe_pkg::dec_t  dec_d;
    logic               alt_sub;
    logic               alt_sr;

    assign instr   = i_fetch.instr;
    assign alt_sub = (instr.r.funct3 == 3'b000);
    assign alt_sr  = (instr.r.funct3 == 3'b101);

    // lui adds its immediate to x0
    assign o_rs1 = (instr.r.opcode == rv_isa_pkg::OPC_LUI) ? '0 : instr.r.rs1;
    assign o_rs2 = instr.r.rs2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field decode
    always_comb
    begin
        dec_d          = '0;
        dec_d.valid    = i_fetch.valid & ~i_redirect.taken;
        dec_d.pc       = i_fetch.pc;
        dec_d.rs1      = o_rs1;
        dec_d.rs2      = o_rs2;
        dec_d.rs1_data = i_rs1_data;
        dec_d.rs2_data = i_rs2_data;
        dec_d.rd       = instr.r.rd;
        dec_d.funct3   = instr.r.funct3;
        dec_d.alu_op   = rv_isa_pkg::ALU_ADD;
        case (instr.r.opcode)
            rv_isa_pkg::OPC_OP:
            begin
                dec_d.wr_en  = 1'b1;
                dec_d.alu_op = rv_isa_pkg::alu_op_e'({instr.r.funct7[5] & (alt_sub | alt_sr),
                                                      instr.r.funct3});
            end
            rv_isa_pkg::OPC_OP_IMM:
            begin
                dec_d.wr_en   = 1'b1;
                dec_d.op2_imm = 1'b1;
                dec_d.imm     = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
                dec_d.alu_op  = rv_isa_pkg::alu_op_e'({instr.i.imm_11_0[10] & alt_sr,
                                                       instr.i.funct3});  // srai only
            end
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC:
            begin
                dec_d.wr_en   = 1'b1;
                dec_d.op1_pc  = (instr.u.opcode == rv_isa_pkg::OPC_AUIPC);
                dec_d.op2_imm = 1'b1;
                dec_d.imm     = {instr.u.imm_31_12, 12'b0};
            end
            rv_isa_pkg::OPC_JAL:
            begin
                dec_d.wr_en  = 1'b1;
                dec_d.is_jal = 1'b1;
                dec_d.imm    = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                                instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            rv_isa_pkg::OPC_JALR:
            begin
                dec_d.wr_en   = 1'b1;
                dec_d.is_jalr = 1'b1;
                dec_d.imm     = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            rv_isa_pkg::OPC_BRANCH:
            begin
                dec_d.is_branch = 1'b1;
                dec_d.imm       = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                                   instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            default:
            begin
                dec_d.wr_en = 1'b0;    // unknown opcode, retire as nop
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_dec <= '0;
        end
        else
        begin
            o_dec <= dec_d;
        end
    end

endmodule

`default_nettype wire

//--- rv_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regs
(
    input  logic                                 i_clk,
    input  logic                                 i_arst_n,
    input  logic [rv_isa_pkg::REG_ADDR_BITS-1:0] i_rs1,
    input  logic [rv_isa_pkg::REG_ADDR_BITS-1:0] i_rs2,
    input  rv_pipe_pkg::retire_t                 i_wr,
    output logic [rv_isa_pkg::XLEN-1:0]          o_rs1_data,
    output logic [rv_isa_pkg::XLEN-1:0]          o_rs2_data
);

    logic [rv_isa_pkg::XLEN-1:0] regs [31:1];    // no storage for x0
    logic                        wr_hit;

    assign wr_hit = i_wr.valid & i_wr.wr_en & (i_wr.rd != '0);

    function automatic logic [rv_isa_pkg::XLEN-1:0] read_port(
        input logic [rv_isa_pkg::REG_ADDR_BITS-1:0] idx
    );
        if (idx == '0)
        begin
            return '0;
        end
        else if (wr_hit && (idx == i_wr.rd))
        begin
            return i_wr.data;    // write-through
        end
        return regs[idx];
    endfunction

    always_comb
    begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int k = 1; k < 32; k++)
            begin
                regs[k] <= '0;
            end
        end
        else if (wr_hit)
        begin
            regs[i_wr.rd] <= i_wr.data;
        end
    end

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute
(
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  rv_pipe_pkg::dec_t      i_dec,
    output rv_pipe_pkg::redirect_t o_redirect,
    output rv_pipe_pkg::retire_t   o_retire
);

    logic [rv_isa_pkg::XLEN-1:0] rs1_val;
    logic [rv_isa_pkg::XLEN-1:0] rs2_val;
    logic [rv_isa_pkg::XLEN-1:0] op1;
    logic [rv_isa_pkg::XLEN-1:0] op2;
    logic [rv_isa_pkg::XLEN-1:0] alu_res;
    logic                        wb_fwd;
    logic                        cond;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand forwarding, distance one
    assign wb_fwd  = o_retire.valid & o_retire.wr_en & (o_retire.rd != '0);
    assign rs1_val = (wb_fwd && o_retire.rd == i_dec.rs1) ? o_retire.data : i_dec.rs1_data;
    assign rs2_val = (wb_fwd && o_retire.rd == i_dec.rs2) ? o_retire.data : i_dec.rs2_data;

    assign op1 = i_dec.op1_pc  ? i_dec.pc  : rs1_val;
    assign op2 = i_dec.op2_imm ? i_dec.imm : rs2_val;

    always_comb
    begin
        case (i_dec.alu_op)
            rv_isa_pkg::ALU_ADD:  alu_res = op1 + op2;
            rv_isa_pkg::ALU_SUB:  alu_res = op1 - op2;
            rv_isa_pkg::ALU_SLL:  alu_res = op1 << op2[4:0];
            rv_isa_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
            rv_isa_pkg::ALU_SLTU: alu_res = {31'b0, op1 < op2};
            rv_isa_pkg::ALU_XOR:  alu_res = op1 ^ op2;
            rv_isa_pkg::ALU_SRL:  alu_res = op1 >> op2[4:0];
            rv_isa_pkg::ALU_SRA:  alu_res = $signed(op1) >>> op2[4:0];
            rv_isa_pkg::ALU_OR:   alu_res = op1 | op2;
            rv_isa_pkg::ALU_AND:  alu_res = op1 & op2;
            default:              alu_res = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch resolution
    always_comb
    begin
        case (i_dec.funct3)
            3'b000:  cond = (rs1_val == rs2_val);
            3'b001:  cond = (rs1_val != rs2_val);
            3'b100:  cond = ($signed(rs1_val) <  $signed(rs2_val));
            3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  cond = (rs1_val <  rs2_val);
            3'b111:  cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;
        endcase
    end

    assign o_redirect.taken  = i_dec.valid & (i_dec.is_jal | i_dec.is_jalr
                                              | (i_dec.is_branch & cond));
    assign o_redirect.target = i_dec.is_jalr ? ((rs1_val + i_dec.imm) & ~32'd1)
                                             : (i_dec.pc + i_dec.imm);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_retire <= '0;
        end
        else
        begin
            o_retire.valid <= i_dec.valid;
            o_retire.wr_en <= i_dec.wr_en;
            o_retire.rd    <= i_dec.rd;
            o_retire.data  <= (i_dec.is_jal | i_dec.is_jalr) ? i_dec.pc + 32'd4 : alu_res;
            o_retire.pc    <= i_dec.pc;
        end
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000,
    parameter int          IADDR_BITS = 16
)
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_instr_ack,
    input  logic [rv_isa_pkg::XLEN-1:0] i_instr_data,
    output logic                        o_instr_req,
    output logic [IADDR_BITS-1:0]       o_instr_addr,
    output rv_pipe_pkg::retire_t        o_retire
);

    rv_pipe_pkg::fetch_t                  fetch;
    rv_pipe_pkg::dec_t                    dec;
    rv_pipe_pkg::redirect_t               redirect;
    logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs1;
    logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs2;
    logic [rv_isa_pkg::XLEN-1:0]          rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]          rs2_data;

    rv_fetch
    #(
        .RESET_ADDR   (RESET_ADDR),
        .IADDR_BITS   (IADDR_BITS)
    )
    u_fetch
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_instr_ack  (i_instr_ack),
        .i_instr_data (i_instr_data),
        .i_redirect   (redirect),
        .o_instr_req  (o_instr_req),
        .o_instr_addr (o_instr_addr),
        .o_fetch      (fetch)
    );

    rv_decode u_decode
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_fetch      (fetch),
        .i_redirect   (redirect),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_dec        (dec)
    );

    rv_regs u_regs
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .i_wr         (o_retire),    // writeback entry is the write port
        .o_rs1_data   (rs1_data),
        .o_rs2_data   (rs2_data)
    );

    rv_execute u_execute
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_dec        (dec),
        .o_redirect   (redirect),
        .o_retire     (o_retire)
    );

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam logic [31:0] RESET_ADDR = 32'h0000_0000;
    localparam int          IADDR_BITS = 16;
    localparam logic [31:0] LOOP_PC    = 32'd144;    // final self-loop
    localparam int          LOOP_RUNS  = 5;

    logic                  i_clk;
    logic                  i_arst_n;
    logic                  i_instr_ack;
    logic [31:0]           instr_data;
    logic                  o_instr_req;
    logic [IADDR_BITS-1:0] o_instr_addr;
    rv_pipe_pkg::retire_t  o_retire;

    logic [31:0] imem [0:63];
    logic [31:0] m_regs [0:31];
    logic [31:0] m_pc;
    logic [31:0] lfsr;
    int          wait_cnt;
    int          loop_cnt;
    int          errors;
    bit          seen_req;
    bit          seen_ack;

    rv_core #(.RESET_ADDR(RESET_ADDR), .IADDR_BITS(IADDR_BITS)) DUT
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_instr_ack  (i_instr_ack),
        .i_instr_data (instr_data),
        .o_instr_req  (o_instr_req),
        .o_instr_addr (o_instr_addr),
        .o_retire     (o_retire)
    );

    assign instr_data = imem[o_instr_addr[7:2]];    // asynchronous read port

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32 22 2 1
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:
            begin
                if (alt)
                begin
                    return $signed(a) >>> b[4:0];    // sign fill
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(output logic [31:0] pc, output logic wr,
                              output logic [4:0] rd, output logic [31:0] data);
        rv_isa_pkg::instr_u w;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        imm_i;
        logic [31:0]        next;
        logic               take;
        w     = imem[m_pc[7:2]];
        a     = m_regs[w.r.rs1];
        b     = m_regs[w.r.rs2];
        imm_i = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
        next  = m_pc + 32'd4;
        pc    = m_pc;
        rd    = w.r.rd;
        wr    = 1'b1;
        data  = '0;
        case (rv_isa_pkg::opcode_e'(w.r.opcode))
            rv_isa_pkg::OPC_OP:     data = alu(w.r.funct3, w.r.funct7[5], a, b);
            rv_isa_pkg::OPC_OP_IMM: data = alu(w.r.funct3, w.r.funct3 == 3'd5 && imm_i[10],
                                               a, imm_i);
            rv_isa_pkg::OPC_LUI:    data = {w.u.imm_31_12, 12'b0};
            rv_isa_pkg::OPC_AUIPC:  data = m_pc + {w.u.imm_31_12, 12'b0};
            rv_isa_pkg::OPC_JAL:
            begin
                data = m_pc + 32'd4;
                next = m_pc + {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12, w.j.imm_11,
                               w.j.imm_10_1, 1'b0};
            end
            rv_isa_pkg::OPC_JALR:
            begin
                data = m_pc + 32'd4;
                next = (a + imm_i) & ~32'd1;
            end
            rv_isa_pkg::OPC_BRANCH:
            begin
                wr = 1'b0;
                case (w.b.funct3)
                    3'd0:    take = a == b;
                    3'd1:    take = a != b;
                    3'd4:    take = $signed(a) < $signed(b);
                    3'd5:    take = $signed(a) >= $signed(b);
                    3'd6:    take = a < b;
                    default: take = a >= b;
                endcase
                if (take)
                begin
                    next = m_pc + {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5,
                                   w.b.imm_4_1, 1'b0};
                end
            end
            default: wr = 1'b0;    // unsupported, no-op
        endcase
        if (wr && rd != 5'd0)
        begin
            m_regs[rd] = data;
        end
        m_pc = next;
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic stop_on_timeout(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "timeout");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program
    initial
    begin
        for (int k = 0; k < 64; k++)
        begin
            imem[k] = {k[24:0], 7'b0};    // unsupported opcode fill
        end
        imem[0]  = {20'h12345, 5'd1, 7'b0110111};               // lui x1
        imem[1]  = enc_i(12'hffb, 5'd0, 3'd0, 5'd2, 7'b0010011); // addi x2 = -5
        imem[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);          // add
        imem[3]  = enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4);          // sub
        imem[4]  = {20'h00001, 5'd5, 7'b0010111};               // auipc
        imem[5]  = enc_r(7'h00, 5'd3, 5'd4, 3'd4, 5'd6);          // xor
        imem[6]  = enc_i(12'h003, 5'd2, 3'd1, 5'd7, 7'b0010011);  // slli
        imem[7]  = enc_i(12'h401, 5'd2, 3'd5, 5'd8, 7'b0010011);  // srai
        imem[8]  = enc_i(12'h004, 5'd0, 3'd0, 5'd10, 7'b0010011);
        imem[9]  = enc_r(7'h00, 5'd10, 5'd2, 3'd5, 5'd9);         // srl
        imem[10] = enc_r(7'h20, 5'd10, 5'd2, 3'd5, 5'd11);        // sra
        imem[11] = enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd12);         // slt
        imem[12] = enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd13);         // sltu
        imem[13] = enc_r(7'h00, 5'd13, 5'd12, 3'd6, 5'd14);       // or
        imem[14] = enc_r(7'h00, 5'd2, 5'd14, 3'd7, 5'd15);        // and
        imem[15] = enc_i(12'h0f0, 5'd2, 3'd6, 5'd16, 7'b0010011); // ori
        imem[16] = enc_i(12'h03c, 5'd16, 3'd7, 5'd17, 7'b0010011);
        imem[17] = enc_b(13'd12, 5'd13, 5'd12, 3'd0);             // beq, not taken
        imem[18] = enc_b(13'd12, 5'd13, 5'd12, 3'd1);             // bne to 21
        imem[19] = enc_i(12'h001, 5'd0, 3'd0, 5'd20, 7'b0010011);
        imem[20] = enc_i(12'h002, 5'd0, 3'd0, 5'd21, 7'b0010011);
        imem[21] = enc_b(13'd8, 5'd0, 5'd2, 3'd4);                // blt
        imem[22] = enc_i(12'h003, 5'd0, 3'd0, 5'd22, 7'b0010011);
        imem[23] = enc_b(13'd8, 5'd1, 5'd2, 3'd7);                // bgeu
        imem[24] = enc_i(12'h004, 5'd0, 3'd0, 5'd23, 7'b0010011);
        imem[25] = enc_j(21'd8, 5'd24);                           // jal x24
        imem[26] = enc_i(12'h005, 5'd0, 3'd0, 5'd25, 7'b0010011);
        imem[27] = enc_i(12'd117, 5'd0, 3'd0, 5'd26, 7'b0010011);
        imem[28] = enc_i(12'd8, 5'd26, 3'd0, 5'd27, 7'b1100111);  // jalr, odd sum
        imem[29] = enc_i(12'h006, 5'd0, 3'd0, 5'd28, 7'b0010011);
        imem[30] = enc_i(12'h007, 5'd0, 3'd0, 5'd29, 7'b0010011);
        imem[31] = enc_j(21'd8, 5'd0);                            // jal x0
        imem[33] = enc_r(7'h00, 5'd24, 5'd0, 3'd0, 5'd30);        // reads x0
        imem[34] = 32'h0000_000b;                                 // custom-0
        imem[35] = enc_b(13'd8, 5'd1, 5'd0, 3'd7);                // bgeu, not taken
        imem[36] = enc_j(21'd0, 5'd0);                            // self-loop
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory ack with 0 to 2 cycles delay
    always @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            i_instr_ack <= 1'b0;
            wait_cnt    <= 0;
        end
        else if (o_instr_req && wait_cnt == 0)
        begin
            lfsr = lfsr_step(lfsr);
            lfsr = lfsr_step(lfsr);
            i_instr_ack <= 1'b1;
            wait_cnt    <= (lfsr[1:0] == 2'd3) ? 2 : int'(lfsr[1:0]);
        end
        else
        begin
            i_instr_ack <= 1'b0;
            if (wait_cnt != 0)
            begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // retire monitor
    always @(posedge i_clk)
    begin
        logic [31:0] e_pc;
        logic [31:0] e_data;
        logic [4:0]  e_rd;
        logic        e_wr;
        if (i_arst_n)
        begin
            if (o_instr_req && !seen_req)
            begin
                seen_req = 1'b1;
                assert (o_instr_addr == RESET_ADDR[IADDR_BITS-1:0])
                    else report_mismatch($sformatf("first addr %h", o_instr_addr));
            end
            assert (!o_retire.valid || seen_ack)
                else report_mismatch("retire before first ack");
            if (o_instr_req && i_instr_ack)
            begin
                seen_ack = 1'b1;
            end
            if (o_retire.valid)
            begin
                model_step(e_pc, e_wr, e_rd, e_data);
                assert (o_retire.pc == e_pc)
                    else report_mismatch($sformatf("pc %h, expected %h", o_retire.pc, e_pc));
                assert (o_retire.wr_en == e_wr)
                    else report_mismatch($sformatf("wr_en wrong at pc %h", e_pc));
                if (e_wr)
                begin
                    assert (o_retire.rd == e_rd && o_retire.data == e_data)
                        else report_mismatch($sformatf("pc %h x%0d=%h, expected x%0d=%h",
                                             e_pc, o_retire.rd, o_retire.data, e_rd, e_data));
                end
                if (e_pc == LOOP_PC)
                begin
                    loop_cnt++;
                end
            end
        end
    end

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #10 i_clk = ~i_clk;
        end
    end

    initial
    begin
        int cycles;
        i_arst_n    <= 1'b0;
        i_instr_ack <= 1'b0;
        lfsr        = 32'hf892_4699;
        m_pc        = RESET_ADDR;
        loop_cnt    = 0;
        errors      = 0;
        seen_req    = 1'b0;
        seen_ack    = 1'b0;
        for (int k = 0; k < 32; k++)
        begin
            m_regs[k] = '0;
        end
        repeat (2) @(posedge i_clk);
        i_arst_n <= 1'b1;
        cycles = 0;
        while (!seen_req)
        begin
            @(posedge i_clk);
            cycles++;
            if (cycles > 20)
            begin
                stop_on_timeout("no instruction request after reset");
            end
        end
        cycles = 0;
        while (loop_cnt < LOOP_RUNS)
        begin
            @(posedge i_clk);
            cycles++;
            if (cycles > 2000)
            begin
                stop_on_timeout("program did not reach its final loop in time");
            end
        end
        if (errors == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("Regression failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- rv_core.f
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FLIST     ?= rv_core.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)
